/* include/fifo_ep_consts.svh */
// Sizing constants for the credit-controlled word FIFO endpoint
// Included by the package and by every RTL module of the endpoint
// Producer credit pool equals the storage depth

`ifndef FIFO_EP_CONSTS_SVH
`define FIFO_EP_CONSTS_SVH

// Width of one data word
`define FEP_DATA_W      32

// Storage entries, also the producer's initial credit count
`define FEP_DEPTH       16

// Occupancy and threshold counts, holds 0 to FEP_DEPTH
`define FEP_CNT_W       5

// Most read grants the egress stage may hold at once
`define FEP_RD_CRED_MAX 4

// Burst length input and burst position counters
`define FEP_BURST_W     5

`endif

/* design/fifo_ep_pkg.sv */
// Shared types for the word FIFO endpoint
// Imported inside each module body, scoped names are used in port lists

`default_nettype none

`include "fifo_ep_consts.svh"

package fifo_ep_pkg;

    // One data word
    typedef logic [`FEP_DATA_W-1:0] data_t;

    // Occupancy, threshold or burst count
    typedef logic [`FEP_CNT_W-1:0] count_t;

    // Policy for the data-available flag
    typedef enum logic [1:0] {
        MODE_NOT_EMPTY = 2'd0,
        MODE_THRESH    = 2'd1,
        MODE_BURST     = 2'd2
    } avail_mode_e;

    // Word moving between pipeline stages
    typedef struct packed {
        logic  valid;
        data_t data;
    } beat_t;

    // Egress send FSM
    typedef enum logic {
        EG_IDLE = 1'b0,
        EG_SEND = 1'b1
    } egress_state_e;

endpackage

`default_nettype wire

/* design/ingress_stage.sv */
// Producer side of the endpoint
// Registers each credited write into a beat for the storage stage,
// and flags accepted words for the availability monitor

`default_nettype none
`timescale 1ns/10ps

`include "fifo_ep_consts.svh"

module ingress_stage (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                wr_valid_i,
    input  wire fifo_ep_pkg::data_t  wr_data_i,
    output fifo_ep_pkg::beat_t       beat_o,
    output logic                     accept_o
);

    import fifo_ep_pkg::*;

    logic  valid_q;
    data_t data_q;

    // Valid bit is control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= wr_valid_i;
        end
    end

    // Payload only loads on a real write
    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            data_q <= wr_data_i;
        end
    end

    always_comb begin
        beat_o.valid = valid_q;
        beat_o.data  = data_q;
    end

    // Producer only writes while it holds a credit,
    // so every registered beat is accepted
    assign accept_o = valid_q;

endmodule

`default_nettype wire

/* design/word_storage.sv */
// Circular buffer between ingress and egress
// Writes every valid beat, presents the oldest word as the head beat,
// and returns one write credit to the producer per popped entry
// Credit flow control keeps it from overflowing

`default_nettype none
`timescale 1ns/10ps

`include "fifo_ep_consts.svh"

module word_storage (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire fifo_ep_pkg::beat_t  beat_i,
    input  wire logic                pop_i,
    output fifo_ep_pkg::beat_t       head_o,
    output logic                     credit_o
);

    import fifo_ep_pkg::*;

    localparam int PTR_W = $clog2(`FEP_DEPTH);

    data_t             mem [`FEP_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    count_t            count;
    logic              credit_q;

    // Entry array
    always_ff @(posedge clk) begin
        if (beat_i.valid) begin
            mem[wr_ptr] <= beat_i.data;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (beat_i.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({beat_i.valid, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Freed slot goes back to the producer one cycle after the pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_q <= 1'b0;
        end else begin
            credit_q <= pop_i;
        end
    end

    assign credit_o = credit_q;

    always_comb begin
        head_o.valid = (count != '0);
        head_o.data  = mem[rd_ptr];
    end

endmodule

`default_nettype wire

/* design/egress_stage.sv */
// Consumer side of the endpoint
// Counts read grants and sends one stored word per grant,
// with rd_valid_o high for one cycle per delivered word

`default_nettype none
`timescale 1ns/10ps

`include "fifo_ep_consts.svh"

module egress_stage (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                rd_credit_i,
    input  wire fifo_ep_pkg::beat_t  head_i,
    output logic                     pop_o,
    output logic                     rd_valid_o,
    output fifo_ep_pkg::data_t       rd_data_o
);

    import fifo_ep_pkg::*;

    localparam int CRED_W = $clog2(`FEP_RD_CRED_MAX + 1);

    logic [CRED_W-1:0] cred_cnt;
    egress_state_e     state;
    data_t             data_q;
    logic              send;

    // Send whenever a grant and a stored word are both there
    assign send  = (cred_cnt != '0) && head_i.valid;
    assign pop_o = send;

    // Grant count, a grant in the same cycle as a send still counts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cred_cnt <= '0;
        end else begin
            cred_cnt <= cred_cnt + CRED_W'(rd_credit_i) - CRED_W'(send);
        end
    end

    // EG_SEND lasts one cycle per word, back to back sends stay in it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= EG_IDLE;
        end else begin
            state <= send ? EG_SEND : EG_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            data_q <= head_i.data;
        end
    end

    assign rd_valid_o = (state == EG_SEND);
    assign rd_data_o  = data_q;

endmodule

`default_nettype wire

/* design/avail_monitor.sv */
// Data-available flag for the consumer
// Tracks the endpoint level and the burst counts from the accepted and
// delivered strobes, then registers the flag for the selected mode
// Counters and flag stay cleared while en_i is low

`default_nettype none
`timescale 1ns/10ps

`include "fifo_ep_consts.svh"

module avail_monitor (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      en_i,
    input  wire fifo_ep_pkg::avail_mode_e  mode_i,
    input  wire fifo_ep_pkg::count_t       thresh_i,
    input  wire fifo_ep_pkg::count_t       burst_len_i,
    input  wire logic                      write_i,
    input  wire logic                      deliver_i,
    output logic                           avail_o
);

    import fifo_ep_pkg::*;

    // One extra bit so the signed burst difference covers -1 to FEP_DEPTH
    localparam int BC_W = `FEP_CNT_W + 1;

    count_t                  level;
    logic [`FEP_BURST_W-1:0] wr_in_burst;
    logic [`FEP_BURST_W-1:0] rd_in_burst;
    logic [`FEP_BURST_W-1:0] burst_last;
    logic [BC_W-1:0]         bursts_done;
    logic [BC_W-1:0]         bursts_begun;
    logic [BC_W-1:0]         burst_diff;
    logic                    avail_nxt;

    assign burst_last = `FEP_BURST_W'(burst_len_i) - 1'b1;
    assign burst_diff = bursts_done - bursts_begun;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level        <= '0;
            wr_in_burst  <= '0;
            rd_in_burst  <= '0;
            bursts_done  <= '0;
            bursts_begun <= '0;
        end else if (!en_i) begin
            level        <= '0;
            wr_in_burst  <= '0;
            rd_in_burst  <= '0;
            bursts_done  <= '0;
            bursts_begun <= '0;
        end else begin
            level <= level + count_t'(write_i) - count_t'(deliver_i);
            // Last write of a burst completes it
            if (write_i) begin
                if (wr_in_burst == burst_last) begin
                    wr_in_burst <= '0;
                    bursts_done <= bursts_done + 1'b1;
                end else begin
                    wr_in_burst <= wr_in_burst + 1'b1;
                end
            end
            // First delivered word of a burst begins it
            if (deliver_i) begin
                if (rd_in_burst == '0) begin
                    bursts_begun <= bursts_begun + 1'b1;
                end
                rd_in_burst <= (rd_in_burst == burst_last) ? '0 : rd_in_burst + 1'b1;
            end
        end
    end

    always_comb begin
        case (mode_i)
            MODE_NOT_EMPTY: avail_nxt = (level != '0);
            MODE_THRESH:    avail_nxt = (level >= thresh_i);
            MODE_BURST:     avail_nxt = ($signed(burst_diff) > 0);
            default:        avail_nxt = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            avail_o <= 1'b0;
        end else begin
            avail_o <= en_i && avail_nxt;
        end
    end

endmodule

`default_nettype wire

/* design/fifo_ep_top.sv */
// Top level of the credit-controlled word FIFO endpoint
// Chains ingress, storage and egress, with the availability monitor
// tapping the accepted and delivered strobes

`default_nettype none
`timescale 1ns/10ps

`include "fifo_ep_consts.svh"

module fifo_ep_top (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      wr_valid_i,
    input  wire fifo_ep_pkg::data_t        wr_data_i,
    output logic                           wr_credit_o,
    input  wire logic                      rd_credit_i,
    output logic                           rd_valid_o,
    output fifo_ep_pkg::data_t             rd_data_o,
    input  wire logic                      en_i,
    input  wire fifo_ep_pkg::avail_mode_e  mode_i,
    input  wire fifo_ep_pkg::count_t       thresh_i,
    input  wire fifo_ep_pkg::count_t       burst_len_i,
    output logic                           avail_o
);

    import fifo_ep_pkg::*;

    beat_t in_beat;
    beat_t head_beat;
    logic  pop;
    logic  accept;

    ingress_stage u_ingress (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_valid_i (wr_valid_i),
        .wr_data_i  (wr_data_i),
        .beat_o     (in_beat),
        .accept_o   (accept)
    );

    word_storage u_storage (
        .clk      (clk),
        .rst_n    (rst_n),
        .beat_i   (in_beat),
        .pop_i    (pop),
        .head_o   (head_beat),
        .credit_o (wr_credit_o)
    );

    egress_stage u_egress (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_credit_i (rd_credit_i),
        .head_i      (head_beat),
        .pop_o       (pop),
        .rd_valid_o  (rd_valid_o),
        .rd_data_o   (rd_data_o)
    );

    // Delivered strobe is the consumer's rd_valid_o
    avail_monitor u_monitor (
        .clk         (clk),
        .rst_n       (rst_n),
        .en_i        (en_i),
        .mode_i      (mode_i),
        .thresh_i    (thresh_i),
        .burst_len_i (burst_len_i),
        .write_i     (accept),
        .deliver_i   (rd_valid_o),
        .avail_o     (avail_o)
    );

endmodule

`default_nettype wire

/* testbench/tb_fifo_ep.sv */
// Testbench for the credit-controlled word FIFO endpoint
// Random credit-respecting traffic against a reference model of the data
// queue, both credit loops and the data-available flag in all three modes

`default_nettype none
`timescale 1ns/10ps

`include "fifo_ep_consts.svh"

module tb_fifo_ep;

    import fifo_ep_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int STALL_CYCLES = 40;
    localparam int RAND_CYCLES  = 400;
    localparam int DRAIN_BUDGET = 100;
    localparam int IDLE_CYCLES  = 24;
    localparam int N_PHASES     = 4;
    localparam int TEST_CYCLES  = RESET_CYCLES +
        N_PHASES * (STALL_CYCLES + RAND_CYCLES + DRAIN_BUDGET + IDLE_CYCLES);

    logic        clk;
    logic        rst_n;
    logic        wr_valid_i;
    data_t       wr_data_i;
    logic        wr_credit_o;
    logic        rd_credit_i;
    logic        rd_valid_o;
    data_t       rd_data_o;
    logic        en_i;
    avail_mode_e mode_i;
    count_t      thresh_i;
    count_t      burst_len_i;
    logic        avail_o;

    // Reference model state
    data_t exp_q[$];
    int    prod_credits;
    int    grants_out;
    int    writes_total;
    int    credits_total;
    int    m_level;
    int    wr_pos;
    int    rd_pos;
    int    bursts_done;
    int    bursts_begun;
    int    wr_pct;
    int    rd_pct;
    logic  wv_prev;
    logic  dlv_prev;

    fifo_ep_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_valid_i  (wr_valid_i),
        .wr_data_i   (wr_data_i),
        .wr_credit_o (wr_credit_o),
        .rd_credit_i (rd_credit_i),
        .rd_valid_o  (rd_valid_o),
        .rd_data_o   (rd_data_o),
        .en_i        (en_i),
        .mode_i      (mode_i),
        .thresh_i    (thresh_i),
        .burst_len_i (burst_len_i),
        .avail_o     (avail_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
        if (actual !== expected) begin
            $display("error: t=%0t %s actual=0x%0h expected=0x%0h",
                     $time, name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic report_failure(string msg);
        $display("%s at t=%0t", msg, $time);
        $display("RESULT: FAIL");
        $fatal(1, "%s", msg);
    endtask

    // One clock cycle of checks, model update and new stimulus
    task automatic step();
        logic rv;
        logic acc;
        logic exp_av;
        int   blen;
        @(negedge clk);
        rv   = rd_valid_o;
        acc  = wv_prev;
        blen = int'(burst_len_i);
        // Flag registered from the counts held before this edge
        case (mode_i)
            MODE_NOT_EMPTY: exp_av = (m_level > 0);
            MODE_THRESH:    exp_av = (m_level >= int'(thresh_i));
            MODE_BURST:     exp_av = (bursts_done > bursts_begun);
            default:        exp_av = 1'b0;
        endcase
        check_value("avail_o", avail_o, en_i && exp_av);
        if (!en_i) begin
            m_level      = 0;
            wr_pos       = 0;
            rd_pos       = 0;
            bursts_done  = 0;
            bursts_begun = 0;
        end else begin
            m_level = m_level + int'(acc) - int'(dlv_prev);
            if (acc) begin
                wr_pos++;
                if (wr_pos == blen) begin
                    wr_pos = 0;
                    bursts_done++;
                end
            end
            if (dlv_prev) begin
                if (rd_pos == 0) begin
                    bursts_begun++;
                end
                rd_pos = (rd_pos == blen - 1) ? 0 : rd_pos + 1;
            end
        end
        if (rv) begin
            if (exp_q.size() == 0) begin
                report_failure("Delivery seen while the endpoint held no word");
            end else begin
                check_value("rd_valid_o with grant held", grants_out > 0, 1);
                check_value("rd_data_o", rd_data_o, exp_q.pop_front());
                grants_out--;
            end
        end
        if (wr_credit_o) begin
            prod_credits++;
            credits_total++;
            check_value("wr_credit_o within depth", prod_credits <= `FEP_DEPTH, 1);
        end
        dlv_prev = rv;
        wv_prev  = wr_valid_i;
        // New stimulus within the credits held
        wr_valid_i  = 1'b0;
        rd_credit_i = 1'b0;
        if (prod_credits > 0 && ($urandom % 100) < wr_pct) begin
            wr_valid_i = 1'b1;
            wr_data_i  = $urandom;
            exp_q.push_back(wr_data_i);
            prod_credits--;
            writes_total++;
        end
        if (grants_out < `FEP_RD_CRED_MAX && ($urandom % 100) < rd_pct) begin
            rd_credit_i = 1'b1;
            grants_out++;
        end
    endtask

    // Credit for the last word returns in the same cycle as its delivery
    task automatic drain_endpoint();
        int cycles;
        cycles = 0;
        wr_pct = 0;
        rd_pct = 100;
        while (exp_q.size() != 0) begin
            if (cycles == DRAIN_BUDGET) begin
                report_failure("Endpoint did not drain within the cycle budget");
            end else begin
                step();
                cycles++;
            end
        end
        check_value("wr_credit_o pulse count", credits_total, writes_total);
    endtask

    task automatic run_phase(avail_mode_e mode, int thresh);
        en_i = 1'b0;
        drain_endpoint();
        // Grants pile up with nothing stored and nothing may be sent
        repeat (IDLE_CYCLES) begin
            step();
        end
        check_value("avail_o while disabled", avail_o, 0);
        mode_i      = mode;
        thresh_i    = count_t'(thresh);
        burst_len_i = count_t'(4);
        step();
        en_i = 1'b1;
        // Fill to full with no new grants
        wr_pct = 90;
        rd_pct = 0;
        repeat (STALL_CYCLES) begin
            step();
        end
        check_value("producer credits at full", prod_credits, 0);
        // Grants resume and free slots restart the producer
        wr_pct = 60;
        rd_pct = 50;
        repeat (RAND_CYCLES) begin
            step();
        end
        drain_endpoint();
    endtask

    initial begin
        #(TEST_CYCLES * 4 * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        void'($urandom(44));
        clk           = 1'b0;
        rst_n         = 1'b0;
        wr_valid_i    = 1'b0;
        wr_data_i     = '0;
        rd_credit_i   = 1'b0;
        en_i          = 1'b0;
        mode_i        = MODE_NOT_EMPTY;
        thresh_i      = '0;
        burst_len_i   = count_t'(4);
        prod_credits  = `FEP_DEPTH;
        grants_out    = 0;
        writes_total  = 0;
        credits_total = 0;
        m_level       = 0;
        wr_pos        = 0;
        rd_pos        = 0;
        bursts_done   = 0;
        bursts_begun  = 0;
        wr_pct        = 0;
        rd_pct        = 0;
        wv_prev       = 1'b0;
        dlv_prev      = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
        end
        rst_n = 1'b1;
        check_value("rd_valid_o after reset", rd_valid_o, 0);
        check_value("wr_credit_o after reset", wr_credit_o, 0);
        check_value("avail_o after reset", avail_o, 0);
        run_phase(MODE_NOT_EMPTY, 1);
        run_phase(MODE_THRESH, 1 + int'($urandom % 8));
        run_phase(MODE_BURST, 1);
        en_i = 1'b0;
        drain_endpoint();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
design/fifo_ep_pkg.sv
design/ingress_stage.sv
design/word_storage.sv
design/egress_stage.sv
design/avail_monitor.sv
design/fifo_ep_top.sv
testbench/tb_fifo_ep.sv

/* Makefile */
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -Wno-fatal
TOP        = tb_fifo_ep
RTL_TOP    = fifo_ep_top
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
PASS_MSG   = RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# The run passes only when the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
